// ==== files.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_preload.sv
verilog/mem_arb.sv
verilog/mem_avl_bridge.sv
verilog/mem_top.sv
tb/tb_clkgen.sv
tb/avl_mem_model.sv
tb/tb_mem_top.sv

// ==== Makefile ====
TOP = tb_mem_top
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "Run did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_mem_top.sv ====
`default_nettype none

`include "mem_cfg.svh"

module tb_mem_top import mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          WAIT_TO    = 400;  // Cycles per handshake wait
	localparam int          DONE_TO    = 4000; // Cycles for the whole preload
	localparam int          RAND_OPS   = 48;
	localparam int          RAND_LINES = 8;
	localparam logic [26:0] RAND_BASE  = 27'h0000200;
	localparam logic [4:0]  BURST_SIZE = 5'd2; // Two 128-bit beats per line

	typedef struct packed {
		logic         wr;
		logic [4:0]   size;
		logic [24:0]  addr;  // 16-byte word address
		logic [127:0] data0; // First write beat
	} burst_rec_t;

	logic          clk, arst_n;
	logic          cli0_valid, cli0_stall, cli0_rvalid, preload_done;
	mem_req_t      cli0_req;
	mem_rsp_t      cli0_rsp;
	logic [24:0]   avl_addr;
	logic [15:0]   avl_be;
	logic [127:0]  avl_wdata, avl_rdata;
	logic [4:0]    avl_size;
	logic          avl_burstbegin, avl_read_req, avl_write_req, avl_ready, avl_rdata_valid;
	logic          burst_stb;
	burst_rec_t    burst;                  // Burst seen by the model
	int            err_cnt, chk_cnt, to_cnt;
	logic          done_at_accept;         // preload_done when the core was taken
	logic [255:0]  sb [logic [26:0]];      // Expected line contents
	burst_rec_t    exp_log [$];
	burst_rec_t    obs_log [$];

	tb_clkgen u_clk (.clk(clk), .arst_n(arst_n));

	mem_top uut (
		.clkrst_mem_clk(clk), .arst_n(arst_n),
		.cli0_valid(cli0_valid), .cli0_req(cli0_req), .cli0_stall(cli0_stall),
		.cli0_rvalid(cli0_rvalid), .cli0_rsp(cli0_rsp), .preload_done(preload_done),
		.avl_addr(avl_addr), .avl_be(avl_be), .avl_wdata(avl_wdata), .avl_size(avl_size),
		.avl_burstbegin(avl_burstbegin), .avl_read_req(avl_read_req),
		.avl_write_req(avl_write_req), .avl_ready(avl_ready), .avl_rdata(avl_rdata),
		.avl_rdata_valid(avl_rdata_valid)
	);

	avl_mem_model u_mem (
		.clk(clk), .arst_n(arst_n),
		.avl_addr(avl_addr), .avl_be(avl_be), .avl_wdata(avl_wdata), .avl_size(avl_size),
		.avl_burstbegin(avl_burstbegin), .avl_read_req(avl_read_req),
		.avl_write_req(avl_write_req), .avl_ready(avl_ready), .avl_rdata(avl_rdata),
		.avl_rdata_valid(avl_rdata_valid), .burst_stb(burst_stb), .burst_rec(burst)
	);

	always @(negedge clk) begin
		if (burst_stb)
			obs_log.push_back(burst);
	end

	// Word k of preload line n is {A5A5, n*8+k}
	function automatic logic [255:0] preload_line(input int n);
		logic [255:0] l;
		for (int k = 0; k < 8; k++)
			l[k*32 +: 32] = {16'hA5A5, 16'(n * 8 + k)};
		return l;
	endfunction

	function automatic logic [255:0] merge_bytes(input logic [255:0] old,
			input logic [255:0] nw, input logic [31:0] be);
		logic [255:0] l;
		l = old;
		for (int b = 0; b < 32; b++)
			if (be[b])
				l[b*8 +: 8] = nw[b*8 +: 8];
		return l;
	endfunction

	function automatic logic [255:0] rand_line();
		logic [255:0] l;
		for (int i = 0; i < 8; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic logic [24:0] word_addr(input logic [26:0] line);
		return 25'(line * 2); // Two words per line
	endfunction

	task automatic check_value(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		to_cnt++;
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!arst_n && n < WAIT_TO) begin
			@(negedge clk);
			n++;
		end
		if (!arst_n)
			report_timeout("reset release");
	endtask

	// Hold valid until stall is low and drop it on the accepting edge
	task automatic issue_request(input mem_req_t r, output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		@(posedge clk);
		cli0_valid <= 1'b1;
		cli0_req   <= r;
		while (!ok && n < WAIT_TO) begin
			@(negedge clk);
			if (!cli0_stall) begin
				ok             = 1'b1;
				done_at_accept = preload_done;
			end
			n++;
			@(posedge clk);
		end
		cli0_valid <= 1'b0;
		if (!ok)
			report_timeout("core request accept");
	endtask

	task automatic write_line(input logic [26:0] addr, input logic [255:0] data,
			input logic [31:0] be);
		mem_req_t r;
		bit       ok;
		r = '{opcode: OP_WRITE, addr: addr, wdata: data, wbe: be};
		exp_log.push_back({1'b1, BURST_SIZE, word_addr(addr), data[127:0]});
		issue_request(r, ok);
		if (ok)
			sb[addr] = merge_bytes(sb.exists(addr) ? sb[addr] : '0, data, be);
	endtask

	task automatic read_and_check(input logic [26:0] addr);
		mem_req_t r;
		bit       ok;
		int       n;
		r = '{opcode: OP_READ, addr: addr, wdata: '0, wbe: '0};
		exp_log.push_back({1'b0, BURST_SIZE, word_addr(addr), 128'h0});
		issue_request(r, ok);
		n = 0;
		while (ok && n < WAIT_TO) begin
			@(negedge clk);
			if (cli0_rvalid) begin
				check_value($sformatf("cli0_rsp.rdata line %h", addr), sb[addr], cli0_rsp.rdata);
				ok = 1'b0; // Done
			end
			n++;
		end
		if (ok)
			report_timeout("read return");
	endtask

	// Round-robin must let the core in before the fill ends
	task automatic core_during_preload();
		write_line(27'h40, rand_line(), 32'hFFFF_FFFF);
		check_value("preload_done at core accept", 256'(0), 256'(done_at_accept));
		read_and_check(27'h40);
	endtask

	task automatic preload_fill();
		int n;
		n = 0;
		while (!preload_done && n < DONE_TO) begin
			@(negedge clk);
			n++;
		end
		if (!preload_done)
			report_timeout("preload done");
		for (int i = 0; i < `MEM_PRELOAD_LINES; i++)
			sb[`MEM_PRELOAD_BASE + 27'(i)] = preload_line(i);
		for (int i = 0; i < `MEM_PRELOAD_LINES; i++)
			read_and_check(`MEM_PRELOAD_BASE + 27'(i));
	endtask

	task automatic write_then_read();
		write_line(27'h80, rand_line(), 32'hFFFF_FFFF);
		read_and_check(27'h80);
		write_line(27'h80, rand_line(), 32'hF00F_3C81); // Partial enables
		read_and_check(27'h80);
	endtask

	task automatic random_traffic();
		logic [26:0] a;
		for (int i = 0; i < RAND_LINES; i++)
			write_line(RAND_BASE + 27'(i), rand_line(), 32'hFFFF_FFFF);
		for (int i = 0; i < RAND_OPS; i++) begin
			a = RAND_BASE + 27'($urandom % RAND_LINES);
			if ($urandom % 2)
				write_line(a, rand_line(), $urandom);
			else
				read_and_check(a);
		end
		for (int i = 0; i < RAND_LINES; i++)
			read_and_check(RAND_BASE + 27'(i)); // Final reads flush every burst into the log
	endtask

	task automatic burst_log_check();
		int n;
		exp_log.delete();
		obs_log.delete();
		write_line(27'h300, rand_line(), 32'hFFFF_FFFF);
		read_and_check(27'h300);
		write_line(27'h301, rand_line(), 32'hFFFF_FFFF);
		write_line(27'h301, rand_line(), 32'h0000_FF0F);
		read_and_check(27'h301);
		n = 0;
		while (obs_log.size() < exp_log.size() && n < WAIT_TO) begin
			@(negedge clk);
			n++;
		end
		if (obs_log.size() < exp_log.size())
			report_timeout("burst log entries");
		check_value("burst log length", 256'(exp_log.size()), 256'(obs_log.size()));
		for (int i = 0; i < exp_log.size() && i < obs_log.size(); i++) begin
			check_value($sformatf("avl_write_req burst %0d", i), 256'(exp_log[i].wr),
				256'(obs_log[i].wr));
			check_value($sformatf("avl_addr burst %0d", i), 256'(exp_log[i].addr),
				256'(obs_log[i].addr));
			check_value($sformatf("avl_size burst %0d", i), 256'(exp_log[i].size),
				256'(obs_log[i].size));
			if (exp_log[i].wr)
				check_value($sformatf("avl_wdata beat 0 burst %0d", i),
					256'(exp_log[i].data0), 256'(obs_log[i].data0));
		end
	endtask

	initial begin
		err_cnt        = 0;
		chk_cnt        = 0;
		to_cnt         = 0;
		done_at_accept = 1'b0;
		cli0_valid     = 1'b0;
		cli0_req       = '0;
		void'($urandom(32'h54adcf7e));
		wait_reset();
		core_during_preload();
		preload_fill();
		write_then_read();
		random_traffic();
		burst_log_check();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/avl_mem_model.sv ====
`default_nettype none

`include "mem_cfg.svh"

module avl_mem_model (
	input  wire           clk,
	input  wire           arst_n,
	input  logic [24:0]   avl_addr,
	input  logic [15:0]   avl_be,
	input  logic [127:0]  avl_wdata,
	input  logic [4:0]    avl_size,
	input  logic          avl_burstbegin,
	input  logic          avl_read_req,
	input  logic          avl_write_req,
	output logic          avl_ready,
	output logic [127:0]  avl_rdata,
	output logic          avl_rdata_valid,
	output logic          burst_stb,   // One pulse per burst start
	output logic [158:0]  burst_rec    // {write, size, addr, first write beat}
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [127:0] words [logic [24:0]]; // Sparse 16-byte word store
	logic [24:0]  wr_base;              // Burst start word
	int unsigned  wr_beat;
	logic         rd_busy;              // Read burst being returned
	logic [24:0]  rd_base;
	int unsigned  rd_beat;
	int unsigned  rd_wait;              // Cycles before next beat

	// Untouched words read back a pattern of their own address
	function automatic logic [127:0] read_word(input logic [24:0] a);
		if (words.exists(a))
			return words[a];
		return {4{7'h0, a}} ^ 128'h0000_0000_1111_1111_2222_2222_3333_3333;
	endfunction

	always @(posedge clk or negedge arst_n) begin
		logic [24:0]  wa;
		logic [127:0] w;
		if (!arst_n) begin
			avl_ready       <= 1'b0;
			avl_rdata       <= '0;
			avl_rdata_valid <= 1'b0;
			burst_stb       <= 1'b0;
			burst_rec       <= '0;
			wr_base         <= '0;
			wr_beat         <= 0;
			rd_busy         <= 1'b0;
			rd_base         <= '0;
			rd_beat         <= 0;
			rd_wait         <= 0;
		end else begin
			avl_ready       <= ($urandom % 4) != 0; // Low about one cycle in four
			avl_rdata_valid <= 1'b0;
			burst_stb       <= 1'b0;
			if (avl_burstbegin && avl_ready) begin // Log each burst start
				burst_stb <= 1'b1;
				burst_rec <= {avl_write_req, avl_size, avl_addr,
					avl_write_req ? avl_wdata : 128'h0};
			end
			if (avl_write_req && avl_ready) begin
				wa = avl_burstbegin ? avl_addr : wr_base + 25'(wr_beat);
				w  = read_word(wa);
				for (int b = 0; b < 16; b++) begin
					if (avl_be[b])
						w[b*8 +: 8] = avl_wdata[b*8 +: 8]; // Byte merge
				end
				words[wa] = w;
				if (avl_burstbegin) begin
					wr_base <= avl_addr;
					wr_beat <= 1;
				end else begin
					wr_beat <= wr_beat + 1;
				end
			end
			if (avl_read_req && avl_ready && !rd_busy) begin
				rd_busy <= 1'b1;
				rd_base <= avl_addr;
				rd_beat <= 0;
				rd_wait <= $urandom % 4; // Random read latency
			end else if (rd_busy) begin
				if (rd_wait != 0) begin
					rd_wait <= rd_wait - 1;
				end else begin
					avl_rdata_valid <= 1'b1;
					avl_rdata       <= read_word(rd_base + 25'(rd_beat)); // Low half first
					rd_beat         <= rd_beat + 1;
					rd_wait         <= $urandom % 2; // Gap between beats
					if (rd_beat == `MEM_AVL_BEATS - 1)
						rd_busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1; // Release on a rising edge
	end

endmodule

`default_nettype wire

// ==== verilog/mem_top.sv ====
`default_nettype none

module mem_top import mem_pkg::*; (
	input  wire           clkrst_mem_clk,
	input  wire           arst_n,
	input  logic          cli0_valid,      // Core client
	input  mem_req_t      cli0_req,
	output logic          cli0_stall,
	output logic          cli0_rvalid,
	output mem_rsp_t      cli0_rsp,
	output logic          preload_done,    // Fill finished
	output logic [24:0]   avl_addr,        // Memory controller port
	output logic [15:0]   avl_be,
	output logic [127:0]  avl_wdata,
	output logic [4:0]    avl_size,
	output logic          avl_burstbegin,
	output logic          avl_read_req,
	output logic          avl_write_req,
	input  logic          avl_ready,
	input  logic [127:0]  avl_rdata,
	input  logic          avl_rdata_valid
);

	logic      pre_valid;  // Preload to arbiter
	mem_req_t  pre_req;
	logic      pre_stall;
	logic      pre_rvalid; // Preload only writes, stays low
	logic      arb_valid;  // Arbiter to bridge
	mem_req_t  arb_req;
	logic      arb_stall;
	logic      arb_rvalid;
	mem_rsp_t  arb_rsp;

	mem_preload u_pre (
		.clkrst_mem_clk (clkrst_mem_clk),
		.arst_n         (arst_n),
		.valid          (pre_valid),
		.req            (pre_req),
		.stall          (pre_stall),
		.done           (preload_done)
	);

	// Client 0 is the core, client 1 is preload
	mem_arb u_arb (
		.clkrst_mem_clk (clkrst_mem_clk),
		.arst_n         (arst_n),
		.cli_valid      ({pre_valid, cli0_valid}),
		.cli_req        ({pre_req, cli0_req}),
		.cli_stall      ({pre_stall, cli0_stall}),
		.cli_rvalid     ({pre_rvalid, cli0_rvalid}),
		.cli_rsp        (cli0_rsp),
		.out_valid      (arb_valid),
		.out_req        (arb_req),
		.out_stall      (arb_stall),
		.out_rvalid     (arb_rvalid),
		.out_rsp        (arb_rsp)
	);

	mem_avl_bridge u_brg (
		.clkrst_mem_clk  (clkrst_mem_clk),
		.arst_n          (arst_n),
		.valid           (arb_valid),
		.req             (arb_req),
		.stall           (arb_stall),
		.rvalid          (arb_rvalid),
		.rsp             (arb_rsp),
		.avl_addr        (avl_addr),
		.avl_be          (avl_be),
		.avl_wdata       (avl_wdata),
		.avl_size        (avl_size),
		.avl_burstbegin  (avl_burstbegin),
		.avl_read_req    (avl_read_req),
		.avl_write_req   (avl_write_req),
		.avl_ready       (avl_ready),
		.avl_rdata       (avl_rdata),
		.avl_rdata_valid (avl_rdata_valid)
	);

endmodule

`default_nettype wire

// ==== verilog/mem_avl_bridge.sv ====
`default_nettype none

`include "mem_cfg.svh"

module mem_avl_bridge import mem_pkg::*; (
	input  wire           clkrst_mem_clk,
	input  wire           arst_n,
	input  logic          valid,           // Line request from arbiter
	input  mem_req_t      req,
	output logic          stall,           // Busy with one request
	output logic          rvalid,          // One-cycle read return
	output mem_rsp_t      rsp,
	output logic [24:0]   avl_addr,        // 16-byte word address
	output logic [15:0]   avl_be,
	output logic [127:0]  avl_wdata,
	output logic [4:0]    avl_size,
	output logic          avl_burstbegin,
	output logic          avl_read_req,
	output logic          avl_write_req,
	input  logic          avl_ready,
	input  logic [127:0]  avl_rdata,
	input  logic          avl_rdata_valid
);

	localparam int BW = (`MEM_AVL_BEATS > 1) ? $clog2(`MEM_AVL_BEATS) : 1;

	typedef enum logic [1:0] {
		S_IDLE,  // Waiting for a request
		S_WR,    // Write beats going out
		S_RDREQ, // Read command held until ready
		S_RDCOL  // Gathering read beats
	} state_t;

	state_t                               state;
	logic [BW-1:0]                        beat;    // Current beat in burst
	logic                                 last;    // Beat is the final one
	mem_req_t                             lat_req; // Request held for the burst
	logic [`MEM_AVL_BEATS-1:0][127:0]     rd_line; // Read beats in arrival order

	assign last = (beat == BW'(`MEM_AVL_BEATS - 1));

	// Payload capture while idle
	always_ff @(posedge clkrst_mem_clk) begin
		if (state == S_IDLE) begin
			lat_req <= req;
		end
		if (state == S_RDCOL && avl_rdata_valid) begin
			rd_line[beat] <= avl_rdata;
		end
	end

	always_ff @(posedge clkrst_mem_clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= S_IDLE;
			beat   <= '0;
			rvalid <= 1'b0;
		end else begin
			rvalid <= 1'b0; // Pulse only
			case (state)
				S_IDLE: begin
					beat <= '0;
					if (valid) begin
						state <= (req.opcode == OP_WRITE) ? S_WR : S_RDREQ;
					end
				end
				S_WR: begin
					if (avl_ready) begin // Beat accepted
						if (last) begin
							state <= S_IDLE; // Stall drops next cycle
							beat  <= '0;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				S_RDREQ: begin
					if (avl_ready) begin
						state <= S_RDCOL;
					end
				end
				S_RDCOL: begin
					if (avl_rdata_valid) begin
						if (last) begin
							state  <= S_IDLE;
							beat   <= '0;
							rvalid <= 1'b1; // Line complete
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign stall     = (state != S_IDLE);
	assign rsp.rdata = rd_line;

	// Line address times 2 with bits above the port dropped
	assign avl_addr       = {lat_req.addr[28:5], 1'b0};
	assign avl_size       = 5'(`MEM_AVL_BEATS);
	assign avl_wdata      = lat_req.wdata[beat*128 +: 128]; // Low half first
	assign avl_be         = lat_req.wbe[beat*16 +: 16];
	assign avl_write_req  = (state == S_WR);
	assign avl_read_req   = (state == S_RDREQ);
	assign avl_burstbegin = (state == S_WR && beat == '0) || (state == S_RDREQ);

	// Controller must not return data unasked
	a_rdata_in_collect: assert property (
		@(posedge clkrst_mem_clk) disable iff (!arst_n)
		avl_rdata_valid |-> (state == S_RDCOL)
	) else $error("rdata_valid outside read collect");

endmodule

`default_nettype wire

// ==== verilog/mem_arb.sv ====
`default_nettype none

`include "mem_cfg.svh"

module mem_arb import mem_pkg::*; (
	input  wire                                clkrst_mem_clk,
	input  wire                                arst_n,
	input  logic     [`MEM_CLIENTS-1:0]        cli_valid,  // Per-client request level
	input  mem_req_t [`MEM_CLIENTS-1:0]        cli_req,    // Per-client request
	output logic     [`MEM_CLIENTS-1:0]        cli_stall,  // Per-client back-pressure
	output logic     [`MEM_CLIENTS-1:0]        cli_rvalid, // Read return to owner only
	output mem_rsp_t                           cli_rsp,    // Broadcast read line
	output logic                               out_valid,  // Toward bridge
	output mem_req_t                           out_req,
	input  logic                               out_stall,
	input  logic                               out_rvalid,
	input  mem_rsp_t                           out_rsp
);

	localparam int N  = `MEM_CLIENTS;
	localparam int CW = (N > 1) ? $clog2(N) : 1;

	logic [CW-1:0] rr_ptr;    // Highest-priority client this cycle
	logic [N-1:0]  grant;     // One-hot winner
	logic [CW-1:0] gnt_idx;   // Winner index
	logic          accept;    // Bridge takes the request
	logic          owner_vld; // A read is outstanding
	logic [CW-1:0] owner_idx; // Who issued it

	// Search upward from rr_ptr with wrap
	always_comb begin
		int j;
		grant   = '0;
		gnt_idx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			j = (int'(rr_ptr) + i) % N;
			if (cli_valid[j]) begin // Downward loop so lowest offset wins
				grant    = '0;
				grant[j] = 1'b1;
				gnt_idx  = CW'(j);
			end
		end
	end

	assign out_valid = |grant;
	assign out_req   = cli_req[gnt_idx]; // Zero-cycle pass-through
	assign accept    = out_valid && !out_stall;
	assign cli_rsp   = out_rsp;          // Data broadcast to every client

	always_comb begin
		for (int i = 0; i < N; i++) begin
			cli_stall[i]  = grant[i] ? out_stall : 1'b1; // Losers always wait
			cli_rvalid[i] = out_rvalid && owner_vld && (owner_idx == CW'(i));
		end
	end

	always_ff @(posedge clkrst_mem_clk or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr    <= '0;
			owner_vld <= 1'b0;
			owner_idx <= '0;
		end else begin
			if (accept) begin
				rr_ptr <= (gnt_idx == CW'(N - 1)) ? '0 : gnt_idx + 1'b1; // Past the winner
			end
			if (accept && out_req.opcode == OP_READ) begin
				owner_vld <= 1'b1; // New read wins over a same-cycle return
				owner_idx <= gnt_idx;
			end else if (out_rvalid) begin
				owner_vld <= 1'b0;
			end
		end
	end

	// Bridge must never return data nobody asked for
	a_rvalid_has_owner: assert property (
		@(posedge clkrst_mem_clk) disable iff (!arst_n)
		out_rvalid |-> owner_vld
	) else $error("read return without pending owner");

endmodule

`default_nettype wire

// ==== verilog/mem_preload.sv ====
`default_nettype none

`include "mem_cfg.svh"

module mem_preload import mem_pkg::*; (
	input  wire       clkrst_mem_clk,
	input  wire       arst_n,
	output logic      valid,   // Write request pending
	output mem_req_t  req,     // Computed fill line
	input  logic      stall,   // Arbiter back-pressure
	output logic      done     // All lines written, sticky
);

	localparam int CNT_W = (`MEM_PRELOAD_LINES > 1) ? $clog2(`MEM_PRELOAD_LINES) : 1;

	logic [CNT_W-1:0] line_cnt; // Index of line being written
	logic             accept;   // Write taken this cycle
	logic             last;     // Current line is the final one

	assign accept = valid && !stall;
	assign last   = (line_cnt == CNT_W'(`MEM_PRELOAD_LINES - 1));

	always_ff @(posedge clkrst_mem_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid    <= 1'b0;
			done     <= 1'b0;
			line_cnt <= '0;
		end else if (!done) begin
			if (accept) begin
				line_cnt <= line_cnt + 1'b1; // Next line
				if (last) begin
					valid <= 1'b0; // Stop issuing
					done  <= 1'b1; // Seen the cycle after last accept
				end
			end else if (!valid) begin
				valid <= 1'b1; // Start right after reset release
			end
		end
	end

	// Fill rule: word k of line n is {A5A5, n*8+k}
	always_comb begin
		req        = '0;
		req.opcode = OP_WRITE;
		req.addr   = `MEM_PRELOAD_BASE + 27'(line_cnt);
		req.wbe    = '1; // Whole line
		for (int k = 0; k < 8; k++) begin
			req.wdata[k*32 +: 32] = {16'hA5A5, 16'({line_cnt, 3'(k)})};
		end
	end

	// Once finished, preload stays silent for good
	a_no_valid_after_done: assert property (
		@(posedge clkrst_mem_clk) disable iff (!arst_n)
		done |=> (done && !valid)
	) else $error("preload raised valid after done");

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// Line opcodes, only two in use
	typedef enum logic [2:0] {
		OP_READ  = 3'b000,
		OP_WRITE = 3'b001
	} mem_op_t;

	// Line request, client to arbiter to bridge
	typedef struct packed {
		mem_op_t       opcode; // Read or write
		logic [31:5]   addr;   // Line address
		logic [255:0]  wdata;  // Full line of write data
		logic [31:0]   wbe;    // One enable per byte
	} mem_req_t;

	// Read return, one line
	typedef struct packed {
		logic [255:0]  rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Arbiter clients, 0 is the core, 1 is preload
`define MEM_CLIENTS 2

// First line address written by preload, byte address bits 31:5
`define MEM_PRELOAD_BASE 27'h0000100

// Number of lines filled after reset
`define MEM_PRELOAD_LINES 16

// 128-bit beats per 256-bit line
`define MEM_AVL_BEATS 2

`endif
